// ==== testbench/scene_stim.txt ====
// record: id orient tile frames at_line probes, then per probe: x y expected_bit (hex)
// entity goes in at x 3f of line at_line in the frame before; first word is the record count
6
2 0 35 3 00 4
14 0c 1
15 0c 0
15 0d 1
17 0e 0
2 1 35 2 3f 3
14 0c 0
17 0c 1
16 0d 1
2 2 c3 2 3f 3
0f 30 1
0c 33 1
0d 33 0
2 3 c3 2 3f 3
0c 33 0
0f 33 1
0d 32 0
c 0 0a 2 14 3
29 00 1
28 00 0
2b 01 0
f 0 35 2 20 2
14 0c 0
17 0f 0

// ==== project.f ====
hdl/scene_pkg.sv
hdl/sprite_rom.sv
hdl/tile_renderer.sv
hdl/pixel_fifo.sv
hdl/vga_scanout.sv
hdl/scene_top.sv
testbench/tb_scene_top.sv

// ==== Bender.yml ====
package:
  name: scene_display

sources:
  - hdl/scene_pkg.sv
  - hdl/sprite_rom.sv
  - hdl/tile_renderer.sv
  - hdl/pixel_fifo.sv
  - hdl/vga_scanout.sv
  - hdl/scene_top.sv
  - target: test
    files:
      - testbench/tb_scene_top.sv

// ==== testbench/tb_scene_top.sv ====
// tb_scene_top: self-checking testbench for the tile display pipeline, driven by the stim file
`timescale 1ns/1ps

module tb_scene_top import scene_pkg::*; ();

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  entity_word_t entity;
  logic         hsync;
  logic         vsync;
  logic [5:0]   rgb;

  logic [7:0] stim [0:255];  // record headers, then x y bit per probe
  integer     seed = 82;
  integer     errors = 0;
  integer     checks = 0;
  integer     cycles = 0;
  integer     limit = 0;
  logic       timed_out = 1'b0;
  logic       done = 1'b0;

  // position of the current rgb sample, rebuilt from sync edges
  integer tx = 0;
  integer ty = 0;
  integer hs_low = 0;     // low samples in the running pulse
  integer vs_low = 0;
  logic   prev_hs = 1'b1;
  logic   prev_vs = 1'b1;
  logic   h_locked = 1'b0;
  logic   v_locked = 1'b0;
  integer rec = 0;        // record on screen
  integer disp_ptr = 1;   // its header in stim
  integer disp_left = 0;  // frames still to show, this one included
  integer rnd_x = -1;
  integer rnd_y = -1;

  scene_top dut (
    .clk    (clk),
    .rst    (rst),
    .entity (entity),
    .hsync  (hsync),
    .vsync  (vsync),
    .rgb    (rgb)
  );

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) cycles <= cycles + 1;

  // header is id orient tile frames at_line probes, 3 words per probe
  function automatic integer next_record(input integer p);
    return p + 6 + 3 * stim[p + 5];
  endfunction

  function automatic logic in_entity_tile(input integer x, input integer y, input integer p);
    return (stim[p] != id_unused) && (y / tile_px == stim[p + 2][7:4]) &&
           (x / tile_px == stim[p + 2][3:0]);
  endfunction

  task automatic load_entity(input integer p);
    entity.flat.id     = stim[p][3:0];
    entity.flat.orient = stim[p + 1][1:0];
    entity.flat.tile   = stim[p + 2];  // row in high nibble
  endtask

  task automatic check_px(input logic [5:0] want, input string what);
    checks++;
    assert (rgb === want) else begin
      errors++;
      $display("Fail at %0t ns: %s at (%0d,%0d) rgb %b, expected %b",
               $time, what, tx, ty, rgb, want);
    end
  endtask

  task automatic check_sync(input integer got, input integer want, input string what);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  always @(negedge clk) begin
    integer nx;
    integer ny;
    integer q;
    if (!rst) begin
      nx = (tx == h_total - 1) ? 0 : tx + 1;
      ny = (tx != h_total - 1) ? ty : (ty == v_total - 1) ? 0 : ty + 1;
      if (prev_hs && !hsync) begin  // hsync falls at h_sync_start
        if (h_locked) check_sync(nx, h_sync_start, "hsync period");
        nx = h_sync_start;
        h_locked = 1'b1;
      end
      if (prev_vs && !vsync) begin
        if (v_locked) check_sync(ny, v_sync_start, "vsync period");
        check_sync(nx, 0, "vsync start pixel");
        ny = v_sync_start;
        v_locked = 1'b1;
      end
      if (!prev_hs && hsync) check_sync(hs_low, h_sync_len, "hsync width");
      if (!prev_vs && vsync) check_sync(vs_low, v_sync_len * h_total, "vsync width");
      hs_low = hsync ? 0 : hs_low + 1;
      vs_low = vsync ? 0 : vs_low + 1;
      tx = nx;
      ty = ny;
      prev_hs = hsync;
      prev_vs = vsync;
      if (v_locked && !done) begin
        if (tx == 0 && ty == 0) begin  // new frame on screen
          disp_left--;
          if (disp_left == 0) begin
            rec++;
            disp_ptr = next_record(disp_ptr);
            disp_left = stim[disp_ptr + 3];
            done = (rec == stim[0]);
          end
          rnd_x = $random(seed) & 63;
          rnd_y = $random(seed) & 63;
          if (in_entity_tile(rnd_x, rnd_y, disp_ptr)) rnd_x = rnd_x ^ 32;  // other tile column
        end
        if (!done && tx < h_active && ty < v_active) begin
          if (in_entity_tile(tx, ty, disp_ptr)) begin
            checks++;
            assert (rgb == colour_fg || rgb == colour_bg) else begin
              errors++;
              $display("Fail at %0t ns: rgb %b at (%0d,%0d) is no palette colour",
                       $time, rgb, tx, ty);
            end
          end else begin
            check_px(colour_bg, "blank tile");
          end
          if (tx == rnd_x && ty == rnd_y) check_px(colour_bg, "random blank probe");
          for (int i = 0; i < stim[disp_ptr + 5]; i++) begin
            q = disp_ptr + 6 + 3 * i;
            if (stim[q] == tx && stim[q + 1] == ty) begin
              check_px(stim[q + 2][0] ? colour_fg : colour_bg, "sprite probe");
            end
          end
        end else if (!done) begin
          check_px(6'd0, "blanking");
        end
        // next entity goes in during the last frame of this record
        if (!done && disp_left == 1 && rec + 1 < stim[0]) begin
          q = next_record(disp_ptr);
          if (tx == h_active - 1 && ty == stim[q + 4]) load_entity(q);
        end
      end
    end
  end

  initial begin
    integer p;
    integer total;
    $readmemh("testbench/scene_stim.txt", stim);
    total = 0;
    p = 1;
    repeat (stim[0]) begin
      total += stim[p + 3];
      p = next_record(p);
    end
    limit = total * h_total * v_total + 200;
    disp_left = stim[4];
    load_entity(1);  // first record is latched straight out of reset
    repeat (2) @(posedge clk);
    @(negedge clk) rst = 1'b0;
    while (!done && cycles < limit) @(negedge clk);
    if (!done) begin
      timed_out = 1'b1;
      $display("timeout: stimulus not finished after %0d cycles", cycles);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== hdl/scene_top.sv ====
// scene_top: renderer, pixel FIFO and VGA scanout joined by the credit loop
`timescale 1ns/1ps

module scene_top import scene_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  entity_word_t entity,
  output logic         hsync,
  output logic         vsync,
  output logic [5:0]   rgb
);

  logic push;
  logic push_bit;
  logic pop;
  logic head_bit;
  logic credit_return;  // scanout back to renderer

  tile_renderer u_renderer (
    .clk           (clk),
    .rst           (rst),
    .entity        (entity),
    .credit_return (credit_return),
    .push          (push),
    .push_bit      (push_bit)
  );

  pixel_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .push_bit (push_bit),
    .pop      (pop),
    .head_bit (head_bit)
  );

  vga_scanout u_scanout (
    .clk           (clk),
    .rst           (rst),
    .head_bit      (head_bit),
    .pop           (pop),
    .credit_return (credit_return),
    .hsync         (hsync),
    .vsync         (vsync),
    .rgb           (rgb)
  );

endmodule

// ==== hdl/vga_scanout.sv ====
// vga_scanout: sync timing generator that pops one pixel per active clock and returns credits
`timescale 1ns/1ps

module vga_scanout import scene_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       head_bit,
  output logic       pop,
  output logic       credit_return,
  output logic       hsync,
  output logic       vsync,
  output logic [5:0] rgb
);

  logic [h_cnt_w-1:0] h_cnt;  // pixel within line
  logic [v_cnt_w-1:0] v_cnt;  // line within frame
  logic               line_end;
  logic               frame_end;
  logic               active;
  logic               hs_raw;
  logic               vs_raw;

  assign line_end  = h_cnt == h_cnt_w'(h_total - 1);
  assign frame_end = v_cnt == v_cnt_w'(v_total - 1);
  assign active    = (h_cnt < h_cnt_w'(h_active)) && (v_cnt < v_cnt_w'(v_active));

  // every active pixel consumes one FIFO slot and frees one credit
  assign pop           = active;
  assign credit_return = active;

  // active low sync pulses
  assign hs_raw = !((h_cnt >= h_cnt_w'(h_sync_start)) && (h_cnt < h_cnt_w'(h_sync_end)));
  assign vs_raw = !((v_cnt >= v_cnt_w'(v_sync_start)) && (v_cnt < v_cnt_w'(v_sync_end)));

  // reset parks on the last pixel of the frame, so pixel 0 of line 0
  // follows one cycle after release
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= h_cnt_w'(h_total - 1);
      v_cnt <= v_cnt_w'(v_total - 1);
    end else if (line_end) begin
      h_cnt <= '0;
      v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // outputs one cycle behind the counters, syncs stay aligned with rgb
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync <= 1'b1;  // idle high
      vsync <= 1'b1;
      rgb   <= '0;
    end else begin
      hsync <= hs_raw;
      vsync <= vs_raw;
      if (active) begin
        rgb <= head_bit ? colour_fg : colour_bg;
      end else begin
        rgb <= '0;  // black in blanking
      end
    end
  end

endmodule

// ==== hdl/pixel_fifo.sv ====
// pixel_fifo: circular buffer of rendered pixel bits between renderer and scanout
`timescale 1ns/1ps

module pixel_fifo import scene_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic push_bit,
  input  logic pop,
  output logic head_bit
);

  logic [fifo_depth-1:0] mem;     // one bit per slot
  logic [fifo_ptr_w-1:0] wr_ptr;  // next slot to fill
  logic [fifo_ptr_w-1:0] rd_ptr;  // oldest pixel

  // credits bound the occupancy, so no full check here
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_bit;
    end
  end

  // depth is a power of two, pointers wrap on overflow
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;  // scanout pops only in active area
    end
  end

  // head is visible without a pop, scanout samples it in the pop cycle
  assign head_bit = mem[rd_ptr];

endmodule

// ==== hdl/tile_renderer.sv ====
// tile_renderer: walks the active raster and pushes one sprite bit per pixel under credit control
`timescale 1ns/1ps

module tile_renderer import scene_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  entity_word_t entity,
  input  logic         credit_return,
  output logic         push,
  output logic         push_bit
);

  logic [pos_w-1:0]    x;        // column of the next pixel to render
  logic [pos_w-1:0]    y;        // line of the next pixel
  logic [credit_w-1:0] credits;  // free slots in the pixel FIFO
  entity_word_t        ent_q;    // entity held for the rest of the frame
  entity_word_t        ent_cur;
  logic                frame_start;
  logic                last_x;
  logic                last_y;
  logic                drained;
  logic                hit;
  logic                sprite_px;

  assign frame_start = (x == '0) && (y == '0);
  assign last_x      = x == pos_w'(h_active - 1);
  assign last_y      = y == pos_w'(v_active - 1);
  assign drained     = credits == credit_w'(fifo_depth);  // FIFO empty, display caught up

  // pixel 0 takes the live input, the rest of the frame the latched copy
  assign ent_cur = frame_start ? entity : ent_q;

  // a new frame waits until the display has taken every pixel of the
  // previous one, so an entity written during blanking lands on the
  // frame shown next
  assign push = (credits != '0) && (!frame_start || drained);

  // tile coordinates from the high bits of the position
  assign hit = (ent_cur.grid.row == y[pos_w-1 -: tile_w]) &&
               (ent_cur.grid.col == x[pos_w-1 -: tile_w]);

  sprite_rom u_sprite_rom (
    .id     (ent_cur.grid.id),
    .orient (ent_cur.grid.orient),
    .row    (y[sub_w-1:0]),  // pixel within the tile
    .col    (x[sub_w-1:0]),
    .px     (sprite_px)
  );

  assign push_bit = hit & sprite_px;  // background elsewhere

  // one credit out per push, one back per pop on the display side
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_w'(fifo_depth);
    end else begin
      credits <= credits + credit_w'(credit_return) - credit_w'(push);
    end
  end

  // raster position, advances only on a push
  always_ff @(posedge clk) begin
    if (rst) begin
      x <= '0;
      y <= '0;
    end else if (push) begin
      if (last_x) begin
        x <= '0;
        y <= last_y ? '0 : y + 1'b1;  // wrap to next frame
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  // sample the entity as pixel 0 goes out
  always_ff @(posedge clk) begin
    if (push && frame_start) begin
      ent_q <= entity;
    end
  end

endmodule

// ==== hdl/sprite_rom.sv ====
// sprite_rom: 4x4 pattern table for 16 entity ids, with orientation flips applied to row and column
`timescale 1ns/1ps

module sprite_rom import scene_pkg::*; (
  input  logic [3:0]       id,
  input  logic [1:0]       orient,
  input  logic [sub_w-1:0] row,
  input  logic [sub_w-1:0] col,
  output logic             px
);

  logic [15:0]      pat;  // row 0 in [15:12], col 0 is msb of each row
  logic [sub_w-1:0] r, c;

  assign r = orient[1] ? ~row : row;  // vertical flip
  assign c = orient[0] ? ~col : col;  // horizontal flip

  always_comb begin
    case (id)
      4'd0:    pat = 16'h6996;  // ring
      4'd1:    pat = 16'hf888;  // corner bracket
      4'd2:    pat = 16'h8cef;  // stair triangle
      4'd3:    pat = 16'hf00f;
      4'd4:    pat = 16'ha5a5;  // checker
      4'd5:    pat = 16'h0660;  // small block
      4'd6:    pat = 16'hc3c3;
      4'd7:    pat = 16'h1248;  // anti-diagonal
      4'd8:    pat = 16'hff00;
      4'd9:    pat = 16'h3c3c;
      4'd10:   pat = 16'h8421;  // diagonal
      4'd11:   pat = 16'he8e8;
      4'd12:   pat = 16'h4e44;  // arrow up
      4'd13:   pat = 16'h9f9f;
      4'd14:   pat = 16'h7531;
      id_unused: pat = 16'h0000;  // nothing drawn
      default: pat = 16'h0000;
    endcase
  end

  assign px = pat[~{r, c}];  // 15 - index, so msb is top left

endmodule

// ==== hdl/scene_pkg.sv ====
// scene_pkg: shared screen timing, tile geometry, FIFO sizing, palette and entity word layout
package scene_pkg;

  // horizontal timing, in pixels
  localparam int h_active   = 64;
  localparam int h_front    = 4;
  localparam int h_sync_len = 8;
  localparam int h_total    = 80;  // leaves 4 px back porch

  // vertical timing, in lines
  localparam int v_active   = 64;
  localparam int v_front    = 2;
  localparam int v_sync_len = 2;
  localparam int v_total    = 70;

  // sync windows, derived from the porches
  localparam int h_sync_start = h_active + h_front;
  localparam int h_sync_end   = h_sync_start + h_sync_len;
  localparam int v_sync_start = v_active + v_front;
  localparam int v_sync_end   = v_sync_start + v_sync_len;

  localparam int h_cnt_w = $clog2(h_total);  // 7 bits for 0..79
  localparam int v_cnt_w = $clog2(v_total);

  // tile grid
  localparam int tile_px    = 4;   // tile edge in pixels
  localparam int grid_tiles = 16;  // tiles per screen edge
  localparam int sub_w      = $clog2(tile_px);     // pixel within tile
  localparam int tile_w     = $clog2(grid_tiles);  // tile index per axis
  localparam int pos_w      = sub_w + tile_w;      // active area position

  // pixel buffer, one slot per credit
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int credit_w   = $clog2(fifo_depth + 1);  // must hold the full count

  localparam logic [3:0] id_unused = 4'hf;  // channel empty

  // palette, rr gg bb
  localparam logic [5:0] colour_fg = 6'b111100;  // yellow
  localparam logic [5:0] colour_bg = 6'b000011;  // blue

  // entity word: [13:10] id, [9:8] orientation, [7:0] location
  typedef struct packed {
    logic [3:0] id;
    logic [1:0] orient;  // bit 0 flips columns, bit 1 flips rows
    logic [7:0] tile;    // row * 16 + col
  } entity_flat_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [1:0]        orient;
    logic [tile_w-1:0] row;  // high nibble of the location
    logic [tile_w-1:0] col;
  } entity_grid_t;

  typedef union packed {
    entity_flat_t flat;
    entity_grid_t grid;
  } entity_word_t;

endpackage
